// File: Bender.yml
package:
  name: fec_encoder

export_include_dirs:
  - .

sources:
  - fec_pkg.sv
  - fec_block_writer.sv
  - fec_pingpong_buffer.sv
  - fec_conv_encoder.sv
  - fec_encoder_top.sv
  - target: test
    files:
      - fec_encoder_tb.sv

// File: fec_block_writer.sv
// FEC input block writer

`timescale 1ns/10ps

`include "fec_consts.svh"

module fec_block_writer
    import fec_pkg::*;
(
    input  logic         clk_100mhz,
    input  logic         rst_n,
    // Upstream bit stream
    input  logic         i_valid,
    input  logic         i_data,
    output logic         o_ready,
    // Bank status from the buffer
    input  logic [1:0]   i_bank_full,
    // Write port towards the buffer
    output logic         o_wr_en,
    output logic         o_wr_data,
    output fec_bank_t    o_wr_bank,
    output fec_bit_idx_t o_wr_idx,
    output logic         o_commit
);

    // Index of the last bit in a block
    localparam fec_bit_idx_t LAST_IDX = fec_bit_idx_t'(`FEC_BLOCK_BITS - 1);

    fec_bank_t    wr_bank;
    fec_bit_idx_t wr_idx;
    logic         accept;
    logic         commit;

    // ---------------------------------------------------------
    // Handshake
    // ---------------------------------------------------------

    // Only a free bank may take new bits
    assign o_ready = ~i_bank_full[wr_bank];

    // Transfer when valid and ready meet
    assign accept = i_valid & o_ready;

    // Last bit of the block closes it
    assign commit = accept & (wr_idx == LAST_IDX);

    // ---------------------------------------------------------
    // Write port, same cycle as the transfer
    // ---------------------------------------------------------

    assign o_wr_en   = accept;
    assign o_wr_data = i_data;
    assign o_wr_bank = wr_bank;
    assign o_wr_idx  = wr_idx;
    assign o_commit  = commit;

    // ---------------------------------------------------------
    // Bit counter and bank pointer
    // ---------------------------------------------------------

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            wr_bank <= 1'b0;
            wr_idx  <= '0;
        end else if (commit) begin
            // Block done, move to the other bank
            wr_idx  <= '0;
            wr_bank <= ~wr_bank;
        end else if (accept) begin
            wr_idx <= wr_idx + fec_bit_idx_t'(1);
        end
    end

endmodule

// File: fec_consts.svh
// FEC encoder constants

`ifndef FEC_CONSTS_SVH
`define FEC_CONSTS_SVH

// ---------------------------------------------------------
// Block geometry
// ---------------------------------------------------------

// Data bits per block
`define FEC_BLOCK_BITS 96

// Coded bits per block, rate 1/2
`define FEC_CODED_BITS 192

// Width of a bit index inside one block
`define FEC_IDX_BITS 7

// ---------------------------------------------------------
// Convolutional code, K = 7
// ---------------------------------------------------------

// Encoder memory, six previous data bits
`define FEC_STATE_BITS 6

// First tail bit, block bits 90..95 seed the state
`define FEC_TAIL_START 90

// Generators, MSB taps the current bit, LSB taps d(i-6)
`define FEC_G1_OCT 7'o171
`define FEC_G2_OCT 7'o133

`endif

// File: fec_conv_encoder.sv
// FEC convolutional encoder core

`timescale 1ns/10ps

`include "fec_consts.svh"

module fec_conv_encoder
    import fec_pkg::*;
(
    input  logic         clk_100mhz,
    input  logic         rst_n,
    // Read port towards the buffer
    output fec_bank_t    o_rd_bank,
    output fec_bit_idx_t o_rd_idx,
    output logic         o_release,
    input  logic         i_rd_data,
    input  fec_state_t   i_rd_tail,
    input  logic         i_rd_full,
    // Coded output stream
    output logic         o_valid,
    output logic         o_data,
    input  logic         i_ready
);

    localparam fec_bit_idx_t LAST_IDX = fec_bit_idx_t'(`FEC_BLOCK_BITS - 1);

    fec_bank_t    rd_bank;
    fec_bit_idx_t rd_idx;
    // Phase of the next coded bit to register
    fec_phase_t   phase;
    // Y95 sits on the output, its transfer ends the block
    logic         last_q;
    fec_state_t   enc_state;

    logic         xfer;
    logic         load;
    fec_state_t   code_state;
    logic [6:0]   code_poly;
    logic         code_bit;

    // One coded bit, taps ordered {d, s1, s2, .. s6}
    function automatic logic fec_code_bit(input logic d, input fec_state_t s,
                                          input logic [6:0] g);
        logic [6:0] taps;
        taps[6] = d;
        for (int k = 0; k < `FEC_STATE_BITS; k++) begin
            taps[5-k] = s[k];
        end
        return ^(taps & g);
    endfunction

    // ---------------------------------------------------------
    // Handshake and block start
    // ---------------------------------------------------------

    assign xfer = o_valid & i_ready;

    // o_valid low means idle, start as soon as the bank is full
    assign load = ~o_valid & i_rd_full;

    // Freed on the final Y transfer
    assign o_release = xfer & last_q;

    assign o_rd_bank = rd_bank;
    assign o_rd_idx  = rd_idx;

    // ---------------------------------------------------------
    // Coded bit, X0 uses the tail state directly
    // ---------------------------------------------------------

    assign code_state = load ? i_rd_tail : enc_state;
    assign code_poly  = (load || phase == PHASE_X) ? `FEC_G1_OCT : `FEC_G2_OCT;
    assign code_bit   = fec_code_bit(i_rd_data, code_state, code_poly);

    // ---------------------------------------------------------
    // Control
    // ---------------------------------------------------------

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            rd_bank <= 1'b0;
            rd_idx  <= '0;
            phase   <= PHASE_X;
            last_q  <= 1'b0;
            o_valid <= 1'b0;
        end else if (load) begin
            // X0 goes out next cycle, Y0 follows
            o_valid <= 1'b1;
            phase   <= PHASE_Y;
        end else if (xfer) begin
            if (last_q) begin
                // Block drained, switch banks and go idle
                o_valid <= 1'b0;
                last_q  <= 1'b0;
                rd_bank <= ~rd_bank;
            end else if (phase == PHASE_Y) begin
                // Y registered, step to the next data bit
                phase <= PHASE_X;
                if (rd_idx == LAST_IDX) begin
                    rd_idx <= '0;
                    last_q <= 1'b1;
                end else begin
                    rd_idx <= rd_idx + fec_bit_idx_t'(1);
                end
            end else begin
                phase <= PHASE_Y;
            end
        end
    end

    // ---------------------------------------------------------
    // State and output data
    // ---------------------------------------------------------

    always_ff @(posedge clk_100mhz) begin
        if (load) begin
            enc_state <= i_rd_tail;
        end else if (xfer && !last_q && phase == PHASE_Y) begin
            // Newest bit enters at the bottom
            enc_state <= {enc_state[`FEC_STATE_BITS-2:0], i_rd_data};
        end
        // Output holds while stalled
        if (load || (xfer && !last_q)) begin
            o_data <= code_bit;
        end
    end

endmodule

// File: fec_ref_model.svh
// Tail-biting encoder reference model

`ifndef FEC_REF_MODEL_SVH
`define FEC_REF_MODEL_SVH

// ------------------------------------------------------------
// Block collector and expected coded stream
// ------------------------------------------------------------

// Bits of the block being collected, in arrival order
logic blk_bits [`FEC_BLOCK_BITS];
int   blk_fill = 0;
// Expected coded bits, oldest block first
logic exp_q [$];

// Data bit i-k with the index wrapped inside the block
function automatic logic past_bit(input int i, input int k);
    return blk_bits[(i - k + `FEC_BLOCK_BITS) % `FEC_BLOCK_BITS];
endfunction

// X then Y for every bit of a complete block
function automatic void push_block_expected();
    logic x_bit;
    logic y_bit;
    for (int i = 0; i < `FEC_BLOCK_BITS; i++) begin
        x_bit = blk_bits[i] ^ past_bit(i, 1) ^ past_bit(i, 2) ^ past_bit(i, 3) ^ past_bit(i, 6);
        y_bit = blk_bits[i] ^ past_bit(i, 2) ^ past_bit(i, 3) ^ past_bit(i, 5) ^ past_bit(i, 6);
        exp_q.push_back(x_bit);
        exp_q.push_back(y_bit);
    end
endfunction

// Collect one accepted bit and expand each full block
function automatic void model_accept_bit(input logic d);
    blk_bits[blk_fill] = d;
    blk_fill++;
    if (blk_fill == `FEC_BLOCK_BITS) begin
        push_block_expected();
        blk_fill = 0;
    end
endfunction

`endif

// File: fec_encoder_tb.sv
// Tail-biting FEC encoder testbench

`timescale 1ns/10ps

`include "fec_consts.svh"

module fec_encoder_tb;

    localparam int unsigned SEED = 32'hdd5a3a38;
    localparam int NUM_BLOCKS = 20;
    // Four cycles per coded bit at the slowest plus margin
    localparam int CYCLE_LIMIT = NUM_BLOCKS * `FEC_CODED_BITS * 4 + 1000;
    // Enough to fill both banks while the output is blocked
    localparam int BP_CYCLES = `FEC_CODED_BITS + 48;

    logic clk_100mhz = 1'b0;
    logic rst_n;
    logic i_valid;
    logic i_data;
    logic i_ready;
    logic o_ready;
    logic o_valid;
    logic o_data;

    // Falling-edge view of both handshakes
    logic in_fire = 1'b0;
    logic hold_pending = 1'b0;
    logic hold_data = 1'b0;
    int   in_count = 0;
    int   out_count = 0;
    int   cycle_count = 0;
    // Chance of i_ready per cycle in percent
    int   ready_pct = 100;
    int   data_errors = 0;
    int   flow_errors = 0;

    `include "fec_ref_model.svh"

    fec_encoder_top uut (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .i_valid    (i_valid),
        .i_data     (i_data),
        .o_ready    (o_ready),
        .o_valid    (o_valid),
        .o_data     (o_data),
        .i_ready    (i_ready)
    );

    always #5 clk_100mhz = ~clk_100mhz;

    // ------------------------------------------------------------
    // Monitor and checker sampled mid-cycle
    // ------------------------------------------------------------

    always @(negedge clk_100mhz) begin
        logic exp_bit;
        // Input transfer on the coming edge
        in_fire = rst_n & i_valid & o_ready;
        if (in_fire) begin
            in_count++;
            model_accept_bit(i_data);
        end
        // A stalled coded bit must hold
        if (hold_pending) begin
            assert (o_valid && o_data == hold_data) else begin
                flow_errors++;
                $display("ERROR %0t: stalled output moved, expected %0b, got valid %0b data %0b",
                         $time, hold_data, o_valid, o_data);
            end
        end
        hold_pending = rst_n & o_valid & ~i_ready;
        hold_data    = o_data;
        if (rst_n && o_valid && i_ready) begin
            out_count++;
            assert (exp_q.size() > 0) else begin
                flow_errors++;
                $display("A coded bit came out that no accepted block accounts for");
            end
            if (exp_q.size() > 0) begin
                exp_bit = exp_q.pop_front();
                assert (o_data == exp_bit) else begin
                    data_errors++;
                    $display("ERROR %0t: coded bit %0d, expected %0b, got %0b",
                             $time, out_count - 1, exp_bit, o_data);
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------

    // One clock with a fresh output-ready draw
    task automatic next_cycle();
        @(posedge clk_100mhz);
        i_ready <= ($urandom_range(99) < ready_pct);
    endtask

    // Random bits at the given valid rate with each held until accepted
    task automatic send_bits(input int n_bits, input int valid_pct);
        int sent;
        sent = 0;
        while (sent < n_bits) begin
            next_cycle();
            if (in_fire) begin
                sent++;
            end
            if (in_fire || !i_valid) begin
                i_valid <= (sent < n_bits) && ($urandom_range(99) < valid_pct);
                i_data  <= 1'($urandom_range(1));
            end
        end
    endtask

    // Wait for the expected stream to empty, then check the count
    task automatic drain_output(input int out_start, input int n_blocks);
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        // Idle tail where a stray coded bit would show
        repeat (8) begin
            next_cycle();
        end
        assert (out_count - out_start == n_blocks * `FEC_CODED_BITS) else begin
            flow_errors++;
            $display("ERROR %0t: expected %0d coded bits, got %0d",
                     $time, n_blocks * `FEC_CODED_BITS, out_count - out_start);
        end
    endtask

    task automatic run_blocks(input int n_blocks, input int valid_pct, input int rdy_pct);
        int out_start;
        out_start = out_count;
        ready_pct = rdy_pct;
        send_bits(n_blocks * `FEC_BLOCK_BITS, valid_pct);
        drain_output(out_start, n_blocks);
    endtask

    // Hang guard
    always @(posedge clk_100mhz) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles with %0d coded bits never seen",
                     cycle_count, exp_q.size());
            $display("Test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------

    initial begin
        int in_start;
        int out_start;
        int taken;
        void'($urandom(SEED));
        rst_n   = 1'b0;
        i_valid = 1'b0;
        i_data  = 1'b0;
        i_ready = 1'b1;
        repeat (5) @(posedge clk_100mhz);
        rst_n <= 1'b1;
        @(negedge clk_100mhz);
        assert (!o_valid && o_ready) else begin
            flow_errors++;
            $display("ERROR %0t: after reset expected valid 0 ready 1, got valid %0b ready %0b",
                     $time, o_valid, o_ready);
        end
        // Single block, back-to-back blocks, then random output stalls
        run_blocks(1, 100, 100);
        run_blocks(NUM_BLOCKS, 100, 100);
        run_blocks(4, 100, 50);
        // Output blocked so both banks fill and the input stalls
        in_start  = in_count;
        out_start = out_count;
        ready_pct = 0;
        next_cycle();
        i_valid <= 1'b1;
        i_data  <= 1'($urandom_range(1));
        repeat (BP_CYCLES) begin
            next_cycle();
            if (in_fire) begin
                i_data <= 1'($urandom_range(1));
            end
        end
        taken = in_count - in_start;
        @(negedge clk_100mhz);
        assert (taken == 2 * `FEC_BLOCK_BITS && !o_ready) else begin
            flow_errors++;
            $display("ERROR %0t: blocked output took %0d bits with ready %0b, expected %0d and 0",
                     $time, taken, o_ready, 2 * `FEC_BLOCK_BITS);
        end
        ready_pct = 100;
        next_cycle();
        i_valid <= 1'b0;
        drain_output(out_start, 2);
        // Gaps on the input side
        run_blocks(4, 60, 100);
        $display("Errors: %0d data, %0d flow", data_errors, flow_errors);
        if (data_errors == 0 && flow_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: fec_encoder_top.sv
// FEC tail-biting encoder top

`timescale 1ns/10ps

module fec_encoder_top
    import fec_pkg::*;
(
    input  logic clk_100mhz,
    input  logic rst_n,
    // Data bits in
    input  logic i_valid,
    input  logic i_data,
    output logic o_ready,
    // Coded bits out
    output logic o_valid,
    output logic o_data,
    input  logic i_ready
);

    // ---------------------------------------------------------
    // Writer to buffer
    // ---------------------------------------------------------

    logic         wr_en;
    logic         wr_data;
    fec_bank_t    wr_bank;
    fec_bit_idx_t wr_idx;
    logic         commit;
    logic [1:0]   bank_full;

    // ---------------------------------------------------------
    // Buffer to encoder
    // ---------------------------------------------------------

    fec_bank_t    rd_bank;
    fec_bit_idx_t rd_idx;
    logic         rd_release;
    logic         rd_data;
    fec_state_t   rd_tail;
    logic         rd_full;

    fec_block_writer u_writer (
        .clk_100mhz  (clk_100mhz),
        .rst_n       (rst_n),
        .i_valid     (i_valid),
        .i_data      (i_data),
        .o_ready     (o_ready),
        .i_bank_full (bank_full),
        .o_wr_en     (wr_en),
        .o_wr_data   (wr_data),
        .o_wr_bank   (wr_bank),
        .o_wr_idx    (wr_idx),
        .o_commit    (commit)
    );

    fec_pingpong_buffer u_buffer (
        .clk_100mhz  (clk_100mhz),
        .rst_n       (rst_n),
        .i_wr_en     (wr_en),
        .i_wr_data   (wr_data),
        .i_wr_bank   (wr_bank),
        .i_wr_idx    (wr_idx),
        .i_commit    (commit),
        .o_bank_full (bank_full),
        .i_rd_bank   (rd_bank),
        .i_rd_idx    (rd_idx),
        .i_release   (rd_release),
        .o_rd_data   (rd_data),
        .o_rd_tail   (rd_tail),
        .o_rd_full   (rd_full)
    );

    fec_conv_encoder u_encoder (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .o_rd_bank  (rd_bank),
        .o_rd_idx   (rd_idx),
        .o_release  (rd_release),
        .i_rd_data  (rd_data),
        .i_rd_tail  (rd_tail),
        .i_rd_full  (rd_full),
        .o_valid    (o_valid),
        .o_data     (o_data),
        .i_ready    (i_ready)
    );

endmodule

// File: fec_pingpong_buffer.sv
// FEC ping-pong block buffer

`timescale 1ns/10ps

`include "fec_consts.svh"

module fec_pingpong_buffer
    import fec_pkg::*;
(
    input  logic         clk_100mhz,
    input  logic         rst_n,
    // Write side, from the block writer
    input  logic         i_wr_en,
    input  logic         i_wr_data,
    input  fec_bank_t    i_wr_bank,
    input  fec_bit_idx_t i_wr_idx,
    input  logic         i_commit,
    output logic [1:0]   o_bank_full,
    // Read side, from the encoder
    input  fec_bank_t    i_rd_bank,
    input  fec_bit_idx_t i_rd_idx,
    input  logic         i_release,
    output logic         o_rd_data,
    output fec_state_t   o_rd_tail,
    output logic         o_rd_full
);

    // Two block-sized banks
    logic [`FEC_BLOCK_BITS-1:0] bank_mem [2];

    // One full flag per bank
    logic [1:0] full_q;
    logic [1:0] set_mask;
    logic [1:0] clr_mask;

    // Bank currently selected for reading
    logic [`FEC_BLOCK_BITS-1:0] rd_word;

    // ---------------------------------------------------------
    // Bank storage
    // ---------------------------------------------------------

    // Single-bit writes, one per accepted input bit
    always_ff @(posedge clk_100mhz) begin
        if (i_wr_en) begin
            bank_mem[i_wr_bank][i_wr_idx] <= i_wr_data;
        end
    end

    // ---------------------------------------------------------
    // Full flags
    // ---------------------------------------------------------

    // Commit marks the write bank, release frees the read bank
    // Both never hit the same bank, the writer skips full banks
    assign set_mask = i_commit  ? (2'b01 << i_wr_bank) : 2'b00;
    assign clr_mask = i_release ? (2'b01 << i_rd_bank) : 2'b00;

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 2'b00;
        end else begin
            full_q <= (full_q | set_mask) & ~clr_mask;
        end
    end

    assign o_bank_full = full_q;

    // ---------------------------------------------------------
    // Read port, combinational
    // ---------------------------------------------------------

    assign rd_word   = bank_mem[i_rd_bank];
    assign o_rd_data = rd_word[i_rd_idx];
    assign o_rd_full = full_q[i_rd_bank];

    // Tail-biting start state from the block's last six bits
    // Bit 95 is the newest, so it lands in state bit 0
    always_comb begin
        for (int k = 0; k < `FEC_STATE_BITS; k++) begin
            o_rd_tail[k] = rd_word[`FEC_TAIL_START + `FEC_STATE_BITS - 1 - k];
        end
    end

endmodule

// File: fec_pkg.sv
// FEC encoder shared types

`include "fec_consts.svh"

package fec_pkg;

    // ---------------------------------------------------------
    // Block addressing
    // ---------------------------------------------------------

    // Bit position inside a block, 0..95
    typedef logic [`FEC_IDX_BITS-1:0] fec_bit_idx_t;

    // Ping-pong bank select
    typedef logic fec_bank_t;

    // ---------------------------------------------------------
    // Encoder state and output phase
    // ---------------------------------------------------------

    // Six previous data bits
    // Bit 0 holds d(i-1), bit 5 holds d(i-6)
    typedef logic [`FEC_STATE_BITS-1:0] fec_state_t;

    // Which coded bit of the pair is produced
    // X uses G1, Y uses G2
    typedef enum logic {
        PHASE_X = 1'b0,
        PHASE_Y = 1'b1
    } fec_phase_t;

endpackage

// File: list.f
+incdir+.
fec_pkg.sv
fec_block_writer.sv
fec_pingpong_buffer.sv
fec_conv_encoder.sv
fec_encoder_top.sv
fec_encoder_tb.sv
